/* verif/fc_stim.txt */
// Test count, then per test: total_in total_out in_offset out_offset net_offset flags ack_cycles
// followed by total_in activations, then per neuron total_in weights with the bias last
0003
// Bias and ReLU on, six neurons over two groups
0004 0006 0010 0040 0000 0003 0011
0100 0080 ff00 0200
0100 0100 0100 0100 0000
0080 ff00 0100 0040 0100
ff00 ff00 0000 0000 0080
0200 0000 0000 0080 ff80
0010 0020 0030 0040 0001
fe00 0100 0100 ff00 0200
// ReLU off, negative sums are stored
0003 0004 0020 0050 0020 0002 000b
0100 ff00 0180
0100 0100 0100 ff00
ff00 0000 0000 0000
0000 0200 0000 ff80
0003 0005 0007 0000
// Bias off, large bias weights
0005 0003 0030 0060 0040 0000 000d
0100 0100 0100 0100 0100
0100 ff00 0080 0000 0000 7fff
ff00 ff00 ff00 0000 0000 0100
0040 0040 0040 0040 0040 8000

/* vlog.f */
hdl/fc_dims_pkg.sv
hdl/fc_regs_pkg.sv
hdl/fc_beat_if.sv
hdl/fc_regs.sv
hdl/img_buf.sv
hdl/fc_feeder.sv
hdl/fc_core.sv
hdl/fc_drain.sv
hdl/fc_top.sv
verif/tb_clk.sv
verif/fc_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= fc_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard hdl/*.sv verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* verif/fc_tb.sv */
module fc_tb;

  localparam int    PERIOD     = 10;
  localparam int    RST_CYCLES = 4;
  localparam string STIM_FILE  = "verif/fc_stim.txt";
  localparam int    STIM_WORDS = 128;
  localparam int    BUF_WORDS  = 2 ** fc_dims_pkg::MEMSIZE;
  // Idle cycles watched for a stray ack
  localparam int    QUIET      = 8;
  localparam int    MARGIN     = 200;

  logic                            clk;
  logic                            xrst;
  logic                            reg_we;
  logic [fc_regs_pkg::REGLOG-1:0]  reg_addr;
  logic [fc_regs_pkg::BWIDTH-1:0]  reg_wdata;
  logic                            net_we;
  logic [fc_dims_pkg::CORELOG-1:0] net_sel;
  logic [fc_dims_pkg::NETSIZE-1:0] net_addr;
  fc_dims_pkg::data_t              net_wdata;
  logic                            host_we;
  logic [fc_dims_pkg::MEMSIZE-1:0] host_addr;
  fc_dims_pkg::data_t              host_wdata;
  fc_dims_pkg::data_t              host_rdata;
  logic                            busy;
  logic                            ack;

  fc_dims_pkg::data_t stim [STIM_WORDS];
  // Expected image buffer contents
  fc_dims_pkg::data_t img [BUF_WORDS];
  int                 limit_cycles = 0;

  tb_clk #(.PERIOD(PERIOD), .RST_CYCLES(RST_CYCLES)) clk0 (.clk, .xrst);

  fc_top dut0 (
    .clk, .xrst, .reg_we, .reg_addr, .reg_wdata,
    .net_we, .net_sel, .net_addr, .net_wdata,
    .host_we, .host_addr, .host_wdata, .host_rdata, .busy, .ack
  );

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else begin
      $display("error: time %0t, %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      abort_run();
    end
  endtask

  // ==========================================================================
  // Host access from one falling edge to the next
  // ==========================================================================
  task automatic reg_write(input logic [fc_regs_pkg::REGLOG-1:0] addr, input int data);
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_we = 1'b0;
  endtask

  task automatic net_write(input int sel, input int addr, input fc_dims_pkg::data_t data);
    net_we    = 1'b1;
    net_sel   = fc_dims_pkg::CORELOG'(sel);
    net_addr  = fc_dims_pkg::NETSIZE'(addr);
    net_wdata = data;
    @(negedge clk);
    net_we = 1'b0;
  endtask

  task automatic buf_write(input int addr, input fc_dims_pkg::data_t data);
    host_we    = 1'b1;
    host_addr  = fc_dims_pkg::MEMSIZE'(addr);
    host_wdata = data;
    img[addr]  = data;
    @(negedge clk);
    host_we = 1'b0;
    check_val("ack", ack, 1'b0);
  endtask

  task automatic buf_read(input int addr, output fc_dims_pkg::data_t data);
    host_addr = fc_dims_pkg::MEMSIZE'(addr);
    @(negedge clk);
    data = host_rdata;
  endtask

  // ==========================================================================
  // Layer model
  // ==========================================================================
  function automatic fc_dims_pkg::data_t neuron_out(input int act, input int wts, input int ti,
                                                    input logic bias_en, input logic relu_en);
    longint acc;
    int     i;
    acc = 0;
    for (i = 0; i < ti; i++)
      acc += longint'(stim[act + i]) * longint'(stim[wts + i]);
    if (bias_en)
      acc += longint'(stim[wts + ti]) <<< fc_dims_pkg::QBITS;
    acc = acc >>> fc_dims_pkg::QBITS;
    if (relu_en && acc < 0)
      acc = 0;
    return fc_dims_pkg::data_t'(acc);
  endfunction

  // Header, activations, then total_in+1 words per neuron
  function automatic int record_len(input int base);
    return 7 + stim[base] + stim[base + 1] * (stim[base] + 1);
  endfunction

  function automatic int test_cycles(input int base);
    int ti;
    int tn;
    ti = stim[base];
    tn = stim[base + 1];
    return ti + tn * (ti + 1) + 5 + 2 * int'(stim[base + 6]) + QUIET + BUF_WORDS + 1;
  endfunction

  task automatic run_test(input int base);
    int ti, tn, in_off, out_off, net_off, flags, lat, act, wts, cycles, n, i, a;
    fc_dims_pkg::data_t got;
    ti      = stim[base];
    tn      = stim[base + 1];
    in_off  = stim[base + 2];
    out_off = stim[base + 3];
    net_off = stim[base + 4];
    flags   = stim[base + 5];
    lat     = stim[base + 6];
    act     = base + 7;
    wts     = act + ti;
    for (i = 0; i < ti; i++)
      buf_write(in_off + i, stim[act + i]);
    // Neuron n lives in core n % CORES, group n / CORES
    for (n = 0; n < tn; n++)
      for (i = 0; i <= ti; i++)
        net_write(n % fc_dims_pkg::CORES, net_off + (n / fc_dims_pkg::CORES) * (ti + 1) + i,
                  stim[wts + n * (ti + 1) + i]);
    reg_write(fc_regs_pkg::REG_SIZES, (tn << fc_dims_pkg::LWIDTH) | ti);
    reg_write(fc_regs_pkg::REG_OFFSETS, (out_off << fc_dims_pkg::LWIDTH) | in_off);
    reg_write(fc_regs_pkg::REG_NET, net_off);
    reg_write(fc_regs_pkg::REG_FLAGS, flags);
    reg_write(fc_regs_pkg::REG_START, 0);
    cycles = 0;
    while (ack !== 1'b1 && cycles <= lat) begin
      check_val("busy", busy, 1'b1);
      // Second start request in the middle of the layer
      reg_we   = cycles == 3;
      reg_addr = fc_regs_pkg::REG_START;
      @(negedge clk);
      cycles++;
    end
    check_val("ack latency", cycles, lat);
    check_val("busy", busy, 1'b0);
    repeat (lat + QUIET) begin
      @(negedge clk);
      check_val("ack", ack, 1'b0);
      check_val("busy", busy, 1'b0);
    end
    for (n = 0; n < tn; n++)
      img[out_off + n] = neuron_out(act, wts + n * (ti + 1), ti, flags[1], flags[0]);
    for (a = 0; a < BUF_WORDS; a++) begin
      buf_read(a, got);
      check_val($sformatf("host_rdata @0x%0h", a), got, img[a]);
    end
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial begin : main
    int ntests;
    int ptr;
    int t;
    int a;
    int total;
    reg_we     = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    net_we     = 1'b0;
    net_sel    = '0;
    net_addr   = '0;
    net_wdata  = '0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    $readmemh(STIM_FILE, stim);
    ntests = stim[0];
    assert (ntests > 0)
    else begin
      $display("no tests found in %s", STIM_FILE);
      abort_run();
    end
    total = RST_CYCLES + QUIET + BUF_WORDS + MARGIN;
    ptr   = 1;
    for (t = 0; t < ntests; t++) begin
      total += test_cycles(ptr);
      ptr   += record_len(ptr);
    end
    limit_cycles = total;

    wait (xrst === 1'b1);
    @(negedge clk);
    repeat (QUIET) begin
      check_val("busy", busy, 1'b0);
      check_val("ack", ack, 1'b0);
      @(negedge clk);
    end
    for (a = 0; a < BUF_WORDS; a++)
      buf_write(a, fc_dims_pkg::data_t'({~a[7:0], a[7:0]}));

    ptr = 1;
    for (t = 0; t < ntests; t++) begin
      run_test(ptr);
      ptr += record_len(ptr);
    end
    $display("Simulation finished: PASS");
    $finish;
  end

  initial begin : watchdog
    wait (limit_cycles > 0);
    #(limit_cycles * PERIOD);
    $display("timeout: the run did not finish within %0d cycles", limit_cycles);
    abort_run();
  end

endmodule

/* verif/tb_clk.sv */
module tb_clk #(
  parameter int PERIOD     = 10,
  parameter int RST_CYCLES = 4
) (
  output logic clk,
  output logic xrst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Release on a falling edge, away from the DUT's sampling edge
  initial begin
    xrst = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    xrst = 1'b1;
  end

endmodule

/* hdl/fc_top.sv */
module fc_top (
  input  logic                             clk,
  input  logic                             xrst,
  // Register writes
  input  logic                             reg_we,
  input  logic [fc_regs_pkg::REGLOG-1:0]   reg_addr,
  input  logic [fc_regs_pkg::BWIDTH-1:0]   reg_wdata,
  // Weight load
  input  logic                             net_we,
  input  logic [fc_dims_pkg::CORELOG-1:0]  net_sel,
  input  logic [fc_dims_pkg::NETSIZE-1:0]  net_addr,
  input  fc_dims_pkg::data_t               net_wdata,
  // Image buffer access
  input  logic                             host_we,
  input  logic [fc_dims_pkg::MEMSIZE-1:0]  host_addr,
  input  fc_dims_pkg::data_t               host_wdata,
  output fc_dims_pkg::data_t               host_rdata,
  output logic                             busy,
  output logic                             ack
);

  //==========================================================================
  // Wires
  //==========================================================================
  fc_regs_pkg::layer_cfg_t         cfg;
  logic                            start;
  logic                            done;
  logic [fc_dims_pkg::MEMSIZE-1:0] rd_addr;
  fc_dims_pkg::data_t              rd_data;
  logic                            dr_we;
  logic [fc_dims_pkg::MEMSIZE-1:0] dr_addr;
  fc_dims_pkg::data_t              dr_wdata;
  logic                            buf_we;
  logic [fc_dims_pkg::MEMSIZE-1:0] buf_addr;
  fc_dims_pkg::data_t              buf_wdata;
  logic [fc_dims_pkg::CORES-1:0]   core_valid;
  fc_dims_pkg::data_t              core_res [fc_dims_pkg::CORES];

  fc_beat_if beat ();

  // Drain owns the shared port while the layer runs
  assign buf_we    = busy ? dr_we    : host_we;
  assign buf_addr  = busy ? dr_addr  : host_addr;
  assign buf_wdata = busy ? dr_wdata : host_wdata;
  assign ack       = done;

  //==========================================================================
  // Blocks
  //==========================================================================
  fc_regs regs0 (.clk, .xrst, .reg_we, .reg_addr, .reg_wdata, .done, .cfg, .start, .busy);

  img_buf buf0 (
    .clk, .rd_addr, .rd_data,
    .wr_we(buf_we), .wr_addr(buf_addr), .wr_data(buf_wdata), .wr_rdata(host_rdata)
  );

  fc_feeder feeder0 (.clk, .xrst, .start, .cfg, .rd_addr, .rd_data, .beat);

  for (genvar c = 0; c < fc_dims_pkg::CORES; c++) begin : g_core
    fc_core core0 (
      .clk, .xrst, .relu_en(cfg.relu_en), .bias_en(cfg.bias_en), .beat,
      .net_we(net_we && net_sel == fc_dims_pkg::CORELOG'(c)), .net_addr, .net_wdata,
      .res_valid(core_valid[c]), .res(core_res[c])
    );
  end

  fc_drain drain0 (
    .clk, .xrst, .start, .cfg, .res_valid(&core_valid), .res(core_res),
    .wr_we(dr_we), .wr_addr(dr_addr), .wr_data(dr_wdata), .done
  );

endmodule

/* hdl/fc_drain.sv */
module fc_drain (
  input  logic                             clk,
  input  logic                             xrst,
  input  logic                             start,
  input  fc_regs_pkg::layer_cfg_t          cfg,
  input  logic                             res_valid,
  input  fc_dims_pkg::data_t               res [fc_dims_pkg::CORES],
  output logic                             wr_we,
  output logic [fc_dims_pkg::MEMSIZE-1:0]  wr_addr,
  output fc_dims_pkg::data_t               wr_data,
  output logic                             done
);

  fc_dims_pkg::data_t              lat [fc_dims_pkg::CORES];
  fc_dims_pkg::cnt_t               nbase;
  fc_dims_pkg::cnt_t               wbase;
  fc_dims_pkg::cnt_t               nidx;
  logic [fc_dims_pkg::CORELOG-1:0] slot;
  logic                            wr_act;
  logic                            last_slot;
  logic                            last_grp;

  assign nidx      = wbase + fc_dims_pkg::cnt_t'(slot);
  assign last_slot = slot == fc_dims_pkg::CORELOG'(fc_dims_pkg::CORES - 1);
  assign last_grp  = wbase + fc_dims_pkg::cnt_t'(fc_dims_pkg::CORES)
                     >= fc_dims_pkg::cnt_t'(cfg.total_out);

  // Neurons past total_out are padding in the last group
  assign wr_we   = wr_act && nidx < fc_dims_pkg::cnt_t'(cfg.total_out);
  assign wr_addr = fc_dims_pkg::MEMSIZE'(cfg.out_offset + nidx);
  assign wr_data = lat[slot];

  always_ff @(posedge clk) begin
    if (res_valid)
      lat <= res;
  end

  // A new group may land on the final slot of the previous one
  always_ff @(posedge clk) begin
    if (!xrst) begin
      nbase  <= '0;
      wbase  <= '0;
      slot   <= '0;
      wr_act <= 1'b0;
      done   <= 1'b0;
    end else begin
      done <= wr_act && last_slot && last_grp;
      if (start)
        nbase <= '0;
      if (res_valid) begin
        wbase  <= nbase;
        nbase  <= nbase + fc_dims_pkg::cnt_t'(fc_dims_pkg::CORES);
        slot   <= '0;
        wr_act <= 1'b1;
      end else if (wr_act) begin
        slot <= slot + 1'b1;
        if (last_slot)
          wr_act <= 1'b0;
      end
    end
  end

endmodule

/* hdl/fc_core.sv */
module fc_core (
  input  logic                             clk,
  input  logic                             xrst,
  input  logic                             relu_en,
  input  logic                             bias_en,
  fc_beat_if.core                          beat,
  input  logic                             net_we,
  input  logic [fc_dims_pkg::NETSIZE-1:0]  net_addr,
  input  fc_dims_pkg::data_t               net_wdata,
  output logic                             res_valid,
  output fc_dims_pkg::data_t               res
);

  fc_dims_pkg::data_t wmem [2**fc_dims_pkg::NETSIZE];
  fc_dims_pkg::data_t wgt;
  fc_dims_pkg::acc_t  acc;
  fc_dims_pkg::acc_t  acc_in;
  fc_dims_pkg::acc_t  prod;
  fc_dims_pkg::acc_t  sum;
  fc_dims_pkg::acc_t  shifted;

  always_ff @(posedge clk) begin
    if (net_we)
      wmem[net_addr] <= net_wdata;
  end

  assign wgt    = wmem[beat.waddr];
  assign acc_in = beat.first ? '0 : acc;
  assign prod   = fc_dims_pkg::acc_t'(beat.data) * fc_dims_pkg::acc_t'(wgt);

  // Bias is scaled up to the product's fixed point
  assign sum     = acc_in + (bias_en ? fc_dims_pkg::acc_t'(wgt) <<< fc_dims_pkg::QBITS : '0);
  assign shifted = sum >>> fc_dims_pkg::QBITS;

  always_ff @(posedge clk) begin
    if (beat.valid && !beat.bias)
      acc <= acc_in + prod;
    if (beat.valid && beat.bias)
      res <= (relu_en && shifted[fc_dims_pkg::ACCWIDTH-1]) ? '0
           : fc_dims_pkg::data_t'(shifted);
  end

  always_ff @(posedge clk) begin
    if (!xrst)
      res_valid <= 1'b0;
    else
      res_valid <= beat.valid && beat.bias;
  end

endmodule

/* hdl/fc_feeder.sv */
module fc_feeder (
  input  logic                             clk,
  input  logic                             xrst,
  input  logic                             start,
  input  fc_regs_pkg::layer_cfg_t          cfg,
  output logic [fc_dims_pkg::MEMSIZE-1:0]  rd_addr,
  input  fc_dims_pkg::data_t               rd_data,
  fc_beat_if.feeder                        beat
);

  logic                            run;
  logic [fc_dims_pkg::LWIDTH-1:0]  idx;
  fc_dims_pkg::cnt_t               gbase;
  logic [fc_dims_pkg::NETSIZE-1:0] wa;
  logic                            last_in;
  logic                            last_grp;
  logic                            v_d;
  logic                            first_d;
  logic                            bias_d;
  logic [fc_dims_pkg::NETSIZE-1:0] wa_d;

  assign last_in  = idx == cfg.total_in;
  assign last_grp = gbase + fc_dims_pkg::cnt_t'(fc_dims_pkg::CORES)
                    >= fc_dims_pkg::cnt_t'(cfg.total_out);
  assign rd_addr  = cfg.in_offset + fc_dims_pkg::MEMSIZE'(idx);

  // Index runs 0..total_in per group with the bias beat last
  always_ff @(posedge clk) begin
    if (!xrst) begin
      run     <= 1'b0;
      idx     <= '0;
      gbase   <= '0;
      wa      <= '0;
      v_d     <= 1'b0;
      first_d <= 1'b0;
      bias_d  <= 1'b0;
    end else begin
      v_d     <= run;
      first_d <= run && idx == '0;
      bias_d  <= run && last_in;
      if (start) begin
        run   <= 1'b1;
        idx   <= '0;
        gbase <= '0;
        wa    <= cfg.net_offset;
      end else if (run) begin
        wa <= wa + 1'b1;
        if (last_in) begin
          idx   <= '0;
          gbase <= gbase + fc_dims_pkg::cnt_t'(fc_dims_pkg::CORES);
          if (last_grp)
            run <= 1'b0;
        end else begin
          idx <= idx + 1'b1;
        end
      end
    end
  end

  // Weight address follows the buffer read latency
  always_ff @(posedge clk) begin
    wa_d <= wa;
  end

  assign beat.valid = v_d;
  assign beat.first = first_d;
  assign beat.bias  = bias_d;
  assign beat.data  = rd_data;
  assign beat.waddr = wa_d;

endmodule

/* hdl/img_buf.sv */
module img_buf (
  input  logic                             clk,
  // Engine read port
  input  logic [fc_dims_pkg::MEMSIZE-1:0]  rd_addr,
  output fc_dims_pkg::data_t               rd_data,
  // Shared host or drain port
  input  logic                             wr_we,
  input  logic [fc_dims_pkg::MEMSIZE-1:0]  wr_addr,
  input  fc_dims_pkg::data_t               wr_data,
  output fc_dims_pkg::data_t               wr_rdata
);

  fc_dims_pkg::data_t mem [2**fc_dims_pkg::MEMSIZE];

  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

  // Read before write on the shared port
  always_ff @(posedge clk) begin
    if (wr_we)
      mem[wr_addr] <= wr_data;
    wr_rdata <= mem[wr_addr];
  end

endmodule

/* hdl/fc_regs.sv */
module fc_regs (
  input  logic                             clk,
  input  logic                             xrst,
  input  logic                             reg_we,
  input  logic [fc_regs_pkg::REGLOG-1:0]   reg_addr,
  input  logic [fc_regs_pkg::BWIDTH-1:0]   reg_wdata,
  input  logic                             done,
  output fc_regs_pkg::layer_cfg_t          cfg,
  output logic                             start,
  output logic                             busy
);

  logic busy_q;
  logic host_wr;

  // busy drops in the ack cycle itself
  assign busy    = busy_q && !done;
  assign host_wr = reg_we && !busy;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      cfg    <= '0;
      start  <= 1'b0;
      busy_q <= 1'b0;
    end else begin
      start <= host_wr && reg_addr == fc_regs_pkg::REG_START;
      if (host_wr && reg_addr == fc_regs_pkg::REG_START)
        busy_q <= 1'b1;
      else if (done)
        busy_q <= 1'b0;
      if (host_wr) begin
        case (reg_addr)
          fc_regs_pkg::REG_SIZES: begin
            cfg.total_in  <= reg_wdata[fc_dims_pkg::LWIDTH-1:0];
            cfg.total_out <= reg_wdata[fc_dims_pkg::LWIDTH +: fc_dims_pkg::LWIDTH];
          end
          fc_regs_pkg::REG_OFFSETS: begin
            cfg.in_offset  <= reg_wdata[fc_dims_pkg::MEMSIZE-1:0];
            cfg.out_offset <= reg_wdata[fc_dims_pkg::LWIDTH +: fc_dims_pkg::MEMSIZE];
          end
          fc_regs_pkg::REG_NET:   cfg.net_offset <= reg_wdata[fc_dims_pkg::NETSIZE-1:0];
          fc_regs_pkg::REG_FLAGS: begin
            cfg.bias_en <= reg_wdata[1];
            cfg.relu_en <= reg_wdata[0];
          end
          default: ;
        endcase
      end
    end
  end

endmodule

/* hdl/fc_beat_if.sv */
interface fc_beat_if;

  logic                            valid;
  // first clears the accumulator and bias closes the group
  logic                            first;
  logic                            bias;
  fc_dims_pkg::data_t              data;
  logic [fc_dims_pkg::NETSIZE-1:0] waddr;

  modport feeder (output valid, first, bias, data, waddr);
  modport core   (input valid, first, bias, data, waddr);

endinterface

/* hdl/fc_regs_pkg.sv */
package fc_regs_pkg;

  localparam int BWIDTH = 32;
  localparam int REGLOG = 3;

  // Register map
  localparam logic [REGLOG-1:0] REG_START   = 3'd0;
  localparam logic [REGLOG-1:0] REG_SIZES   = 3'd1;
  localparam logic [REGLOG-1:0] REG_OFFSETS = 3'd2;
  localparam logic [REGLOG-1:0] REG_NET     = 3'd3;
  localparam logic [REGLOG-1:0] REG_FLAGS   = 3'd4;

  typedef struct packed {
    logic [fc_dims_pkg::LWIDTH-1:0]  total_in;
    logic [fc_dims_pkg::LWIDTH-1:0]  total_out;
    logic [fc_dims_pkg::MEMSIZE-1:0] in_offset;
    logic [fc_dims_pkg::MEMSIZE-1:0] out_offset;
    logic [fc_dims_pkg::NETSIZE-1:0] net_offset;
    logic                            bias_en;
    logic                            relu_en;
  } layer_cfg_t;

endpackage

/* hdl/fc_dims_pkg.sv */
package fc_dims_pkg;

  // Datapath widths
  localparam int DWIDTH   = 16;
  localparam int ACCWIDTH = 40;
  localparam int QBITS    = 8;

  // Core array and memory sizes
  localparam int CORES    = 4;
  localparam int CORELOG  = 2;
  localparam int NETSIZE  = 8;
  localparam int MEMSIZE  = 8;
  localparam int LWIDTH   = 8;

  typedef logic signed [DWIDTH-1:0]   data_t;
  typedef logic signed [ACCWIDTH-1:0] acc_t;
  // Neuron count with one carry bit
  typedef logic [LWIDTH:0]            cnt_t;

endpackage
